//--- Makefile
# Verilator build and run of the BPU testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module bpu_tb -f all.f -Mdir obj_dir
	./obj_dir/Vbpu_tb 2>&1 | tee sim.log
	@if grep -q "TESTBENCH FAILED" sim.log; then exit 1; fi
	@grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- all.f
rtl/bpu_cfg_pkg.sv
rtl/bpu_types_pkg.sv
rtl/pred_table.sv
rtl/ftb.sv
rtl/bimodal_predictor.sv
rtl/fetch_block_gen.sv
rtl/bpu_update_ctrl.sv
rtl/bpu.sv
sim/bpu_assert.sv
sim/bpu_tb.sv

//--- rtl/bimodal_predictor.sv
////////////////////
// Untagged bimodal direction predictor
// Only conditional updates touch the counters
////////////////////

`timescale 1ns/1ps
`default_nettype none

module bimodal_predictor #(
    parameter int DEPTH = bpu_cfg_pkg::FTB_DEPTH
) (
    input  logic                               clk,
    input  logic                               rst_i,
    // Query
    input  logic [bpu_cfg_pkg::ADDR_WIDTH-1:0] query_pc_i,
    output bpu_types_pkg::ctr_t                ctr_o,
    // Update
    input  logic                               upd_we_i,
    input  logic                               upd_conditional_i,
    input  logic                               upd_taken_i,
    input  logic [bpu_cfg_pkg::ADDR_WIDTH-1:0] upd_pc_i
);

    import bpu_types_pkg::*;

    localparam int   IDX_W   = $clog2(DEPTH);
    localparam ctr_t CTR_MAX = '1;

    logic [IDX_W-1:0] query_idx;
    logic [IDX_W-1:0] upd_idx;
    logic             ctr_we;
    ctr_t             ctr_cur;
    ctr_t             ctr_nxt;

    assign query_idx = query_pc_i[IDX_W+1:2];
    assign upd_idx   = upd_pc_i[IDX_W+1:2];
    assign ctr_we    = upd_we_i & upd_conditional_i;

    // Saturating step from the value stored at the update index
    always_comb begin
        if (upd_taken_i) begin
            ctr_nxt = (ctr_cur == CTR_MAX) ? ctr_cur : ctr_cur + 1'b1;
        end else begin
            ctr_nxt = (ctr_cur == '0) ? ctr_cur : ctr_cur - 1'b1;
        end
    end

    pred_table #(
        .DEPTH     (DEPTH),
        .entry_t   (ctr_t),
        .RESET_VAL (CTR_RESET)
    ) u_table (
        .clk          (clk),
        .rst_i        (rst_i),
        .rd_idx_i     (query_idx),
        .rd_data_o    (ctr_o),
        .wr_en_i      (ctr_we),
        .wr_idx_i     (upd_idx),
        .wr_data_i    (ctr_nxt),
        .wr_rd_data_o (ctr_cur)
    );

endmodule

`default_nettype wire

//--- rtl/bpu.sv
////////////////////
// Branch prediction unit top
// Prediction is combinational from pc_i
// Training arrives over a four-phase req/ack handshake
////////////////////

`timescale 1ns/1ps
`default_nettype none

module bpu #(
    parameter int DEPTH = bpu_cfg_pkg::FTB_DEPTH
) (
    input  logic                                              clk,
    input  logic                                              rst_i,
    // Prediction
    input  logic [bpu_cfg_pkg::ADDR_WIDTH-1:0]                pc_i,
    input  logic                                              ftq_full_i,
    output logic                                              blk_valid_o,
    output logic [bpu_cfg_pkg::ADDR_WIDTH-1:0]                blk_start_pc_o,
    output logic [$clog2(bpu_cfg_pkg::INSTR_PER_BLOCK+1)-1:0] blk_length_o,
    output logic                                              blk_cross_line_o,
    output logic                                              blk_taken_o,
    output logic                                              redirect_o,
    output logic [bpu_cfg_pkg::ADDR_WIDTH-1:0]                redirect_pc_o,
    // Training
    input  logic                                              upd_req_i,
    output logic                                              upd_ack_o,
    input  logic [bpu_cfg_pkg::ADDR_WIDTH-1:0]                upd_pc_i,
    input  logic                                              upd_conditional_i,
    input  logic                                              upd_taken_i,
    input  logic [bpu_cfg_pkg::ADDR_WIDTH-1:0]                upd_target_i,
    input  logic [bpu_cfg_pkg::ADDR_WIDTH-1:0]                upd_fall_through_i
);

    import bpu_types_pkg::*;

    logic       upd_we;
    logic       ftb_hit;
    ftb_entry_t ftb_entry;
    ctr_t       ctr;

    ////////////////////
    // Training path
    ////////////////////

    bpu_update_ctrl u_update_ctrl (
        .clk       (clk),
        .rst_i     (rst_i),
        .upd_req_i (upd_req_i),
        .upd_ack_o (upd_ack_o),
        .upd_we_o  (upd_we)
    );

    ////////////////////
    // Prediction tables
    ////////////////////

    ftb #(
        .DEPTH (DEPTH)
    ) u_ftb (
        .clk                (clk),
        .rst_i              (rst_i),
        .query_pc_i         (pc_i),
        .hit_o              (ftb_hit),
        .entry_o            (ftb_entry),
        .upd_we_i           (upd_we),
        .upd_pc_i           (upd_pc_i),
        .upd_conditional_i  (upd_conditional_i),
        .upd_target_i       (upd_target_i),
        .upd_fall_through_i (upd_fall_through_i)
    );

    bimodal_predictor #(
        .DEPTH (DEPTH)
    ) u_bimodal (
        .clk               (clk),
        .rst_i             (rst_i),
        .query_pc_i        (pc_i),
        .ctr_o             (ctr),
        .upd_we_i          (upd_we),
        .upd_conditional_i (upd_conditional_i),
        .upd_taken_i       (upd_taken_i),
        .upd_pc_i          (upd_pc_i)
    );

    // Block output toward the FTQ
    fetch_block_gen u_block_gen (
        .pc_i             (pc_i),
        .ftq_full_i       (ftq_full_i),
        .ftb_hit_i        (ftb_hit),
        .ftb_entry_i      (ftb_entry),
        .ctr_i            (ctr),
        .blk_valid_o      (blk_valid_o),
        .blk_start_pc_o   (blk_start_pc_o),
        .blk_length_o     (blk_length_o),
        .blk_cross_line_o (blk_cross_line_o),
        .blk_taken_o      (blk_taken_o),
        .redirect_o       (redirect_o),
        .redirect_pc_o    (redirect_pc_o)
    );

endmodule

`default_nettype wire

//--- rtl/bpu_cfg_pkg.sv
////////////////////
// Geometry of the branch prediction unit
// Byte addresses, 4-byte instructions, 16-byte lines, 4 KiB pages
// FTB_DEPTH must be a power of two
////////////////////

`default_nettype none

package bpu_cfg_pkg;

    // Address and table sizing
    localparam int ADDR_WIDTH      = 32;
    localparam int FTB_DEPTH       = 64;
    localparam int CTR_WIDTH       = 2;

    // Fetch block and memory geometry
    localparam int INSTR_PER_BLOCK = 4;
    localparam int PAGE_BITS       = 12;
    localparam int LINE_BITS       = 4;

endpackage

`default_nettype wire

//--- rtl/bpu_types_pkg.sv
////////////////////
// FTB entry and counter types
// Tag width is fixed by the default FTB depth
////////////////////

`default_nettype none

package bpu_types_pkg;

    import bpu_cfg_pkg::*;

    // Upper PC bits above index and byte offset
    localparam int TAG_WIDTH = ADDR_WIDTH - $clog2(FTB_DEPTH) - 2;

    typedef struct packed {
        logic                  valid;
        logic [TAG_WIDTH-1:0]  tag;
        logic                  is_conditional;
        logic [ADDR_WIDTH-1:0] jump_target;
        logic [ADDR_WIDTH-1:0] fall_through;
    } ftb_entry_t;

    typedef logic [CTR_WIDTH-1:0] ctr_t;

    localparam ftb_entry_t FTB_RESET_ENTRY = '0;
    // Weakly not taken
    localparam ctr_t       CTR_RESET       = ctr_t'(1);

endpackage

`default_nettype wire

//--- rtl/bpu_update_ctrl.sv
////////////////////
// Four-phase req/ack receiver for training updates
// Exactly one write pulse per request
////////////////////

`timescale 1ns/1ps
`default_nettype none

module bpu_update_ctrl (
    input  logic clk,
    input  logic rst_i,
    input  logic upd_req_i,
    output logic upd_ack_o,
    output logic upd_we_o
);

    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        WRITE = 2'd1,
        HOLD  = 2'd2
    } state_t;

    state_t state;
    state_t state_nxt;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:    if (upd_req_i) state_nxt = WRITE;
            // Ack is up from here on, wait for req to fall
            WRITE:   state_nxt = upd_req_i ? HOLD : IDLE;
            HOLD:    if (!upd_req_i) state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    assign upd_ack_o = (state != IDLE);
    assign upd_we_o  = (state == WRITE);

endmodule

`default_nettype wire

//--- rtl/fetch_block_gen.sv
////////////////////
// Fetch block former, purely combinational
// Assumes pc_i is 4-byte aligned
// Block fields other than valid are don't-care while the FTQ is full
////////////////////

`timescale 1ns/1ps
`default_nettype none

module fetch_block_gen (
    input  logic [bpu_cfg_pkg::ADDR_WIDTH-1:0]                pc_i,
    input  logic                                              ftq_full_i,
    input  logic                                              ftb_hit_i,
    input  bpu_types_pkg::ftb_entry_t                         ftb_entry_i,
    input  bpu_types_pkg::ctr_t                               ctr_i,
    output logic                                              blk_valid_o,
    output logic [bpu_cfg_pkg::ADDR_WIDTH-1:0]                blk_start_pc_o,
    output logic [$clog2(bpu_cfg_pkg::INSTR_PER_BLOCK+1)-1:0] blk_length_o,
    output logic                                              blk_cross_line_o,
    output logic                                              blk_taken_o,
    output logic                                              redirect_o,
    output logic [bpu_cfg_pkg::ADDR_WIDTH-1:0]                redirect_pc_o
);

    import bpu_cfg_pkg::*;
    import bpu_types_pkg::*;

    localparam int LEN_W  = $clog2(INSTR_PER_BLOCK + 1);
    localparam int SLOT_W = PAGE_BITS - 2;

    logic                  taken;
    logic [ADDR_WIDTH-1:0] taken_span;
    logic [ADDR_WIDTH-1:0] last_instr_pc;
    logic                  taken_cross;
    logic [SLOT_W:0]       slots_left;
    logic                  page_cut;
    logic [LEN_W-1:0]      seq_len;
    logic                  seq_cross;

    // Conditional entries follow the counter's top bit
    assign taken = ftb_hit_i && (!ftb_entry_i.is_conditional || ctr_i[CTR_WIDTH-1]);

    ////////////////////
    // Taken block
    ////////////////////

    assign taken_span    = ftb_entry_i.fall_through - pc_i;
    assign last_instr_pc = ftb_entry_i.fall_through - ADDR_WIDTH'(4);
    assign taken_cross   = pc_i[ADDR_WIDTH-1:LINE_BITS]
                           != last_instr_pc[ADDR_WIDTH-1:LINE_BITS];

    ////////////////////
    // Sequential block
    ////////////////////

    // Instruction slots left before the page boundary
    assign slots_left = {1'b1, {SLOT_W{1'b0}}} - {1'b0, pc_i[PAGE_BITS-1:2]};
    assign page_cut   = slots_left < (SLOT_W+1)'(INSTR_PER_BLOCK);
    assign seq_len    = page_cut ? slots_left[LEN_W-1:0] : LEN_W'(INSTR_PER_BLOCK);
    assign seq_cross  = (pc_i[LINE_BITS-1:0] != '0) && !page_cut;

    // Outputs, masked by the FTQ full flag
    assign blk_valid_o      = !ftq_full_i;
    assign blk_start_pc_o   = pc_i;
    assign blk_length_o     = taken ? taken_span[LEN_W+1:2] : seq_len;
    assign blk_cross_line_o = taken ? taken_cross : seq_cross;
    assign blk_taken_o      = taken;
    assign redirect_o       = taken && !ftq_full_i;
    assign redirect_pc_o    = redirect_o ? ftb_entry_i.jump_target : '0;

endmodule

`default_nettype wire

//--- rtl/ftb.sv
////////////////////
// Tag-matched fetch target buffer
// Full tag coverage only when DEPTH equals FTB_DEPTH
// An update always overwrites its slot
////////////////////

`timescale 1ns/1ps
`default_nettype none

module ftb #(
    parameter int DEPTH = bpu_cfg_pkg::FTB_DEPTH
) (
    input  logic                               clk,
    input  logic                               rst_i,
    // Query
    input  logic [bpu_cfg_pkg::ADDR_WIDTH-1:0] query_pc_i,
    output logic                               hit_o,
    output bpu_types_pkg::ftb_entry_t          entry_o,
    // Update
    input  logic                               upd_we_i,
    input  logic [bpu_cfg_pkg::ADDR_WIDTH-1:0] upd_pc_i,
    input  logic                               upd_conditional_i,
    input  logic [bpu_cfg_pkg::ADDR_WIDTH-1:0] upd_target_i,
    input  logic [bpu_cfg_pkg::ADDR_WIDTH-1:0] upd_fall_through_i
);

    import bpu_cfg_pkg::*;
    import bpu_types_pkg::*;

    localparam int IDX_W = $clog2(DEPTH);

    logic [IDX_W-1:0]     query_idx;
    logic [IDX_W-1:0]     upd_idx;
    logic [TAG_WIDTH-1:0] query_tag;
    ftb_entry_t           upd_entry;

    // Index sits just above the byte offset, tag takes the top bits
    assign query_idx = query_pc_i[IDX_W+1:2];
    assign upd_idx   = upd_pc_i[IDX_W+1:2];
    assign query_tag = query_pc_i[ADDR_WIDTH-1 -: TAG_WIDTH];

    assign hit_o = entry_o.valid && (entry_o.tag == query_tag);

    always_comb begin
        upd_entry.valid          = 1'b1;
        upd_entry.tag            = upd_pc_i[ADDR_WIDTH-1 -: TAG_WIDTH];
        upd_entry.is_conditional = upd_conditional_i;
        upd_entry.jump_target    = upd_target_i;
        upd_entry.fall_through   = upd_fall_through_i;
    end

    pred_table #(
        .DEPTH     (DEPTH),
        .entry_t   (ftb_entry_t),
        .RESET_VAL (FTB_RESET_ENTRY)
    ) u_table (
        .clk          (clk),
        .rst_i        (rst_i),
        .rd_idx_i     (query_idx),
        .rd_data_o    (entry_o),
        .wr_en_i      (upd_we_i),
        .wr_idx_i     (upd_idx),
        .wr_data_i    (upd_entry),
        .wr_rd_data_o ()
    );

endmodule

`default_nettype wire

//--- rtl/pred_table.sv
////////////////////
// Direct-mapped register table, one read and one write port
// Reads are combinational, writes land on the next edge
// Reset loads RESET_VAL into every slot
////////////////////

`timescale 1ns/1ps
`default_nettype none

module pred_table #(
    parameter int     DEPTH     = bpu_cfg_pkg::FTB_DEPTH,
    parameter type    entry_t   = logic [bpu_cfg_pkg::CTR_WIDTH-1:0],
    parameter entry_t RESET_VAL = '0
) (
    input  logic                     clk,
    input  logic                     rst_i,
    input  logic [$clog2(DEPTH)-1:0] rd_idx_i,
    output entry_t                   rd_data_o,
    input  logic                     wr_en_i,
    input  logic [$clog2(DEPTH)-1:0] wr_idx_i,
    input  entry_t                   wr_data_i,
    output entry_t                   wr_rd_data_o
);

    entry_t mem [DEPTH];

    // Prediction read
    assign rd_data_o    = mem[rd_idx_i];
    // Current slot contents for read-modify-write
    assign wr_rd_data_o = mem[wr_idx_i];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= RESET_VAL;
            end
        end else if (wr_en_i) begin
            mem[wr_idx_i] <= wr_data_i;
        end
    end

endmodule

`default_nettype wire

//--- sim/bpu_assert.sv
////////////////////
// Protocol and output rules of the BPU
// Bound into bpu, sees the internal write pulse
////////////////////

`timescale 1ns/1ps
`default_nettype none

module bpu_assert (
    input logic clk,
    input logic rst_i,
    input logic req_i,
    input logic ack_i,
    input logic we_i,
    input logic ftq_full_i,
    input logic blk_valid_i,
    input logic redirect_i
);

    ack_rise_needs_req: assert property (@(posedge clk) disable iff (rst_i)
        $rose(ack_i) |-> $past(req_i))
        else $error("upd_ack_o rose without a pending request");

    // Write only in the first ack cycle
    no_write_in_hold: assert property (@(posedge clk) disable iff (rst_i)
        we_i |-> !$past(ack_i))
        else $error("table write while upd_ack_o was already high");

    redirect_needs_valid: assert property (@(posedge clk) disable iff (rst_i)
        redirect_i |-> blk_valid_i)
        else $error("redirect_o high without blk_valid_o");

    full_blocks_output: assert property (@(posedge clk) disable iff (rst_i)
        ftq_full_i |-> !blk_valid_i && !redirect_i)
        else $error("block or redirect issued while ftq_full_i is high");

endmodule

bind bpu bpu_assert u_assert (
    .clk         (clk),
    .rst_i       (rst_i),
    .req_i       (upd_req_i),
    .ack_i       (upd_ack_o),
    .we_i        (upd_we),
    .ftq_full_i  (ftq_full_i),
    .blk_valid_i (blk_valid_o),
    .redirect_i  (redirect_o)
);

`default_nettype wire

//--- sim/bpu_tb.sv
////////////////////
// Testbench for the branch prediction unit
// Random PCs come from a small pool so that hits and aliasing both occur
// Inputs change on the rising edge, outputs are sampled on the falling edge
////////////////////

`timescale 1ns/1ps
`default_nettype none

module bpu_tb;

    import bpu_cfg_pkg::*;
    import bpu_types_pkg::*;

    localparam int IDX_W   = $clog2(FTB_DEPTH);
    localparam int LEN_W   = $clog2(INSTR_PER_BLOCK + 1);
    localparam int POOL    = 12;
    localparam int TIMEOUT = 50;

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [LEN_W-1:0]      len_t;

    logic  clk;
    logic  rst_i;
    addr_t pc_i;
    logic  ftq_full_i;
    logic  blk_valid_o;
    addr_t blk_start_pc_o;
    len_t  blk_length_o;
    logic  blk_cross_line_o;
    logic  blk_taken_o;
    logic  redirect_o;
    addr_t redirect_pc_o;
    logic  upd_req_i;
    logic  upd_ack_o;
    addr_t upd_pc_i;
    logic  upd_conditional_i;
    logic  upd_taken_i;
    addr_t upd_target_i;
    addr_t upd_fall_through_i;

    // Model of the tables, FTB keyed by index
    ftb_entry_t ftb_model [int];
    ctr_t       ctr_model [FTB_DEPTH];
    addr_t      pool [POOL];
    integer     seed;

    bpu DUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////
    // Reporting and compare tasks
    ////////////////////

    task automatic stop_with_failure(input string why);
        $display("TESTBENCH FAILED");
        $fatal(1, "%s", why);
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s got 0x%08h expected 0x%08h", $time, name, got, exp);
            stop_with_failure({name, " mismatch"});
        end
    endtask

    task automatic check_len(input string name, input len_t got, input len_t exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s got %0d expected %0d", $time, name, got, exp);
            stop_with_failure({name, " mismatch"});
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s got %b expected %b", $time, name, got, exp);
            stop_with_failure({name, " mismatch"});
        end
    endtask

    ////////////////////
    // Reference prediction
    ////////////////////

    function automatic int idx_of(input addr_t pc);
        return int'(pc[IDX_W+1:2]);
    endfunction

    function automatic void expect_block(input addr_t pc, output logic taken,
                                         output addr_t target, output len_t len,
                                         output logic xline);
        ftb_entry_t e;
        logic       hit;
        int         left;
        e   = FTB_RESET_ENTRY;
        hit = 1'b0;
        if (ftb_model.exists(idx_of(pc))) begin
            e   = ftb_model[idx_of(pc)];
            hit = (e.tag == pc[ADDR_WIDTH-1 -: TAG_WIDTH]);
        end
        // Conditional entries need the counter's top bit
        taken = hit && (!e.is_conditional || ctr_model[idx_of(pc)][CTR_WIDTH-1]);
        if (taken) begin
            target = e.jump_target;
            len    = len_t'((e.fall_through - pc) >> 2);
            xline  = (pc >> LINE_BITS) != ((e.fall_through - 4) >> LINE_BITS);
        end else begin
            target = '0;
            left   = ((1 << PAGE_BITS) - int'(pc[PAGE_BITS-1:0])) / 4;
            len    = len_t'((left < INSTR_PER_BLOCK) ? left : INSTR_PER_BLOCK);
            xline  = (pc[LINE_BITS-1:0] != '0) && (left >= INSTR_PER_BLOCK);
        end
    endfunction

    task automatic drive_and_check(input addr_t pc, input logic full);
        logic  taken;
        addr_t target;
        len_t  len;
        logic  xline;
        @(posedge clk);
        pc_i       <= pc;
        ftq_full_i <= full;
        @(negedge clk);
        expect_block(pc, taken, target, len, xline);
        if (full) begin
            check_flag("blk_valid_o", blk_valid_o, 1'b0);
            check_flag("redirect_o", redirect_o, 1'b0);
        end else begin
            check_flag("blk_valid_o", blk_valid_o, 1'b1);
            check_addr("blk_start_pc_o", blk_start_pc_o, pc);
            check_len("blk_length_o", blk_length_o, len);
            check_flag("blk_cross_line_o", blk_cross_line_o, xline);
            check_flag("blk_taken_o", blk_taken_o, taken);
            check_flag("redirect_o", redirect_o, taken);
            check_addr("redirect_pc_o", redirect_pc_o, target);
        end
    endtask

    ////////////////////
    // Training over the four-phase handshake
    ////////////////////

    task automatic train(input addr_t pc, input logic cond, input logic taken,
                         input addr_t target, input addr_t ft, input int hold);
        int         waited;
        ftb_entry_t e;
        @(posedge clk);
        upd_pc_i           <= pc;
        upd_conditional_i  <= cond;
        upd_taken_i        <= taken;
        upd_target_i       <= target;
        upd_fall_through_i <= ft;
        upd_req_i          <= 1'b1;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT) stop_with_failure("Timeout waiting for upd_ack_o to rise");
        end while (upd_ack_o !== 1'b1);
        // Ack is due one cycle after req is sampled high
        if (waited != 2) stop_with_failure("upd_ack_o did not rise one cycle after upd_req_i");
        repeat (hold) begin
            @(negedge clk);
            check_flag("upd_ack_o", upd_ack_o, 1'b1);
        end
        @(posedge clk);
        upd_req_i <= 1'b0;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT) stop_with_failure("Timeout waiting for upd_ack_o to fall");
        end while (upd_ack_o !== 1'b0);
        // One handshake is one update, however long req was held
        e.valid          = 1'b1;
        e.tag            = pc[ADDR_WIDTH-1 -: TAG_WIDTH];
        e.is_conditional = cond;
        e.jump_target    = target;
        e.fall_through   = ft;
        ftb_model[idx_of(pc)] = e;
        if (cond) begin
            if (taken && ctr_model[idx_of(pc)] != '1) begin
                ctr_model[idx_of(pc)] = ctr_model[idx_of(pc)] + 1'b1;
            end else if (!taken && ctr_model[idx_of(pc)] != '0) begin
                ctr_model[idx_of(pc)] = ctr_model[idx_of(pc)] - 1'b1;
            end
        end
    endtask

    initial begin
        addr_t       pc;
        addr_t       ft;
        logic [31:0] r;
        logic [31:0] r2;
        int          k;
        seed               = 32'h46cf005e;
        rst_i              = 1'b1;
        pc_i               = '0;
        ftq_full_i         = 1'b0;
        upd_req_i          = 1'b0;
        upd_pc_i           = '0;
        upd_conditional_i  = 1'b0;
        upd_taken_i        = 1'b0;
        upd_target_i       = '0;
        upd_fall_through_i = '0;
        for (k = 0; k < FTB_DEPTH; k++) begin
            ctr_model[k] = CTR_RESET;
        end
        // Four pages, few indices, every third PC near a page end
        for (k = 0; k < POOL; k++) begin
            r  = $random(seed);
            pc = {20'h00080 + {18'h0, r[13:12]}, 12'h000};
            if (k % 3 == 0) begin
                pc[11:0] = {8'hFF, r[3:2], 2'b00};
            end else begin
                pc[11:0] = {3'b000, r[8], 3'b000, r[4:2], 2'b00};
            end
            pool[k] = pc;
        end
        repeat (16) @(posedge clk);
        rst_i <= 1'b0;

        // Cleared tables give sequential blocks only
        for (k = 0; k < POOL; k++) begin
            drive_and_check(pool[k], 1'b0);
        end
        repeat (20) begin
            r = $random(seed);
            drive_and_check({r[31:2], 2'b00}, 1'b0);
        end

        // Long req hold must still step the counter once
        r = $random(seed);
        train(pool[1], 1'b1, 1'b1, {r[31:2], 2'b00}, pool[1] + 32'd8, 6);
        drive_and_check(pool[1], 1'b0);
        train(pool[1], 1'b1, 1'b0, {r[31:2], 2'b00}, pool[1] + 32'd8, 0);
        drive_and_check(pool[1], 1'b0);

        // Unconditional branch, three instructions long
        r  = $random(seed);
        pc = pool[2];
        train(pc, 1'b0, 1'b1, {r[31:2], 2'b00}, pc + 32'd12, 1);
        drive_and_check(pc, 1'b0);
        check_flag("blk_taken_o", blk_taken_o, 1'b1);
        check_len("blk_length_o", blk_length_o, len_t'(3));
        check_addr("redirect_pc_o", redirect_pc_o, {r[31:2], 2'b00});

        // Same index, other tag
        drive_and_check(pc ^ 32'h0010_0000, 1'b0);
        check_flag("blk_taken_o", blk_taken_o, 1'b0);

        // Mixed training and prediction with random back-pressure
        repeat (400) begin
            r  = $random(seed);
            r2 = $random(seed);
            pc = pool[int'(r[15:12]) % POOL];
            if (r[1:0] == 2'b00) begin
                ft = pc + ({30'h0, r[6:5]} + 32'd1) * 32'd4;
                train(pc, r[2] | r[3], r[4], {r2[31:2], 2'b00}, ft, int'(r[9:8]));
            end else begin
                drive_and_check(pc, r[7] & r[10]);
            end
        end

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire
